//--- logic/qerv_consts.svh
`ifndef QERV_CONSTS_SVH
`define QERV_CONSTS_SVH

// Datapath geometry
`define QERV_XLEN      32
`define QERV_W         4
`define QERV_NIBBLES   8
`define QERV_CNT_BITS  3
`define QERV_REG_BITS  5

`define QERV_RESET_PC  32'h0000_0100

// Major opcodes of the supported subset
`define QERV_OPC_OP      7'b0110011
`define QERV_OPC_OP_IMM  7'b0010011
`define QERV_OPC_LUI     7'b0110111

`define QERV_F3_ADD  3'b000
`define QERV_F3_XOR  3'b100
`define QERV_F3_OR   3'b110
`define QERV_F3_AND  3'b111
`define QERV_F7_SUB  7'b0100000

`endif

//--- logic/qerv_pkg.sv
`include "qerv_consts.svh"

package qerv_pkg;

   typedef logic [`QERV_W-1:0]        nibble_t;
   typedef logic [`QERV_REG_BITS-1:0] reg_idx_t;
   typedef logic [`QERV_CNT_BITS-1:0] cnt_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_t;

   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [19:0] imm20;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   // Same instruction word seen as R, I or U format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      u_fmt_t u;
   } insn_t;

endpackage

//--- logic/qerv_if.sv
`include "qerv_consts.svh"

// One decoded instruction handed from fetch to the sequencer
interface qerv_issue_if;
   import qerv_pkg::*;

   logic                  valid;
   logic                  ready;
   alu_op_t               alu_op;
   reg_idx_t              rs1;
   reg_idx_t              rs2;
   reg_idx_t              rd;
   logic [`QERV_XLEN-1:0] imm;
   logic                  use_imm;
   logic                  zero_a;

   modport producer (
      output valid, alu_op, rs1, rs2, rd, imm, use_imm, zero_a,
      input  ready
   );

   modport buffer (
      input  valid, alu_op, rs1, rs2, rd, imm, use_imm, zero_a,
      output ready
   );
endinterface

// Operand nibbles streamed into the serial ALU
interface qerv_nibble_if;
   import qerv_pkg::*;

   logic     en;
   logic     first;
   nibble_t  a;
   nibble_t  b;
   alu_op_t  alu_op;
   reg_idx_t rd;

   modport buffer (output en, first, a, b, alu_op, rd);

   modport consumer (input en, first, a, b, alu_op, rd);
endinterface

//--- logic/qerv_fetch.sv
`include "qerv_consts.svh"

module qerv_fetch (
   input  logic                  clk,
   input  logic                  i_rst_n,
   output logic                  o_ibus_cyc,
   output logic [`QERV_XLEN-1:0] o_ibus_adr,
   input  logic [`QERV_XLEN-1:0] i_ibus_dat,
   input  logic                  i_ibus_ack,
   qerv_issue_if.producer        issue
);
   import qerv_pkg::*;

   logic [`QERV_XLEN-1:0] pc_q;
   logic                  cyc_q;
   logic                  valid_q;
   insn_t                 insn_q;
   logic                  take;
   logic                  start;
   alu_op_t               dec_op;
   logic [`QERV_XLEN-1:0] dec_imm;
   logic                  dec_use_imm;
   logic                  dec_zero_a;
   logic                  dec_ok;
   logic                  r_plain;

   assign take  = valid_q && issue.ready;
   // New fetch as soon as the slot is empty or being emptied
   assign start = !cyc_q && (!valid_q || take);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q    <= `QERV_RESET_PC;
         cyc_q   <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         if (cyc_q && i_ibus_ack) begin
            cyc_q   <= 1'b0;
            valid_q <= 1'b1;
         end else if (start) begin
            cyc_q <= 1'b1;
         end
         if (take) begin
            valid_q <= 1'b0;
            pc_q    <= pc_q + `QERV_XLEN'd4;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cyc_q && i_ibus_ack)
         insn_q <= i_ibus_dat;
   end

   assign r_plain = insn_q.r.funct7 == 7'd0;

   always_comb begin
      dec_op      = ALU_ADD;
      dec_imm     = '0;
      dec_use_imm = 1'b0;
      dec_zero_a  = 1'b0;
      dec_ok      = 1'b0;
      case (insn_q.r.opcode)
         `QERV_OPC_OP: begin
            case (insn_q.r.funct3)
               `QERV_F3_ADD: begin
                  dec_op = (insn_q.r.funct7 == `QERV_F7_SUB) ? ALU_SUB : ALU_ADD;
                  dec_ok = r_plain || (insn_q.r.funct7 == `QERV_F7_SUB);
               end
               `QERV_F3_XOR: begin
                  dec_op = ALU_XOR;
                  dec_ok = r_plain;
               end
               `QERV_F3_OR: begin
                  dec_op = ALU_OR;
                  dec_ok = r_plain;
               end
               `QERV_F3_AND: begin
                  dec_op = ALU_AND;
                  dec_ok = r_plain;
               end
               default: dec_ok = 1'b0;
            endcase
         end
         `QERV_OPC_OP_IMM: begin
            dec_imm     = {{(`QERV_XLEN-12){insn_q.i.imm12[11]}}, insn_q.i.imm12};
            dec_use_imm = 1'b1;
            dec_ok      = 1'b1;
            case (insn_q.i.funct3)
               `QERV_F3_ADD: dec_op = ALU_ADD;
               `QERV_F3_XOR: dec_op = ALU_XOR;
               `QERV_F3_OR:  dec_op = ALU_OR;
               `QERV_F3_AND: dec_op = ALU_AND;
               default:      dec_ok = 1'b0;
            endcase
         end
         `QERV_OPC_LUI: begin
            dec_imm     = {insn_q.u.imm20, 12'd0};
            dec_use_imm = 1'b1;
            dec_zero_a  = 1'b1;
            dec_op      = ALU_PASS_B;
            dec_ok      = 1'b1;
         end
         default: dec_ok = 1'b0;
      endcase
   end

   assign o_ibus_cyc    = cyc_q;
   assign o_ibus_adr    = pc_q;

   assign issue.valid   = valid_q;
   assign issue.alu_op  = dec_op;
   assign issue.rs1     = insn_q.r.rs1;
   assign issue.rs2     = insn_q.r.rs2;
   // Unsupported words retire through x0
   assign issue.rd      = dec_ok ? insn_q.r.rd : '0;
   assign issue.imm     = dec_imm;
   assign issue.use_imm = dec_use_imm;
   assign issue.zero_a  = dec_zero_a;

endmodule

//--- logic/qerv_operand_seq.sv
`include "qerv_consts.svh"

module qerv_operand_seq (
   input  logic               clk,
   input  logic               i_rst_n,
   qerv_issue_if.buffer       issue,
   output logic               o_rf_rreq,
   output qerv_pkg::reg_idx_t o_rf_rreg0,
   output qerv_pkg::reg_idx_t o_rf_rreg1,
   input  logic               i_rf_ready,
   input  qerv_pkg::nibble_t  i_rf_rdata0,
   input  qerv_pkg::nibble_t  i_rf_rdata1,
   qerv_nibble_if.buffer      nib
);
   import qerv_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,
      S_WAIT,
      S_RUN
   } state_t;

   state_t                state_q;
   cnt_t                  cnt_q;
   logic                  last;
   logic                  take;
   alu_op_t               op_q;
   reg_idx_t              rs1_q;
   reg_idx_t              rs2_q;
   reg_idx_t              rd_q;
   logic [`QERV_XLEN-1:0] imm_q;
   logic                  use_imm_q;
   logic                  zero_a_q;

   assign last = (state_q == S_RUN) && (cnt_q == `QERV_CNT_BITS'(`QERV_NIBBLES - 1));
   // Accept the next instruction during the final nibble
   assign issue.ready = (state_q == S_IDLE) || last;
   assign take        = issue.valid && issue.ready;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            S_IDLE: if (take) state_q <= S_REQ;
            S_REQ:  state_q <= S_WAIT;
            S_WAIT: begin
               if (i_rf_ready) begin
                  state_q <= S_RUN;
                  cnt_q   <= '0;
               end
            end
            S_RUN: begin
               cnt_q <= cnt_q + cnt_t'(1);
               if (last)
                  state_q <= take ? S_REQ : S_IDLE;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         op_q      <= issue.alu_op;
         rs1_q     <= issue.rs1;
         rs2_q     <= issue.rs2;
         rd_q      <= issue.rd;
         imm_q     <= issue.imm;
         use_imm_q <= issue.use_imm;
         zero_a_q  <= issue.zero_a;
      end else if (nib.en) begin
         imm_q <= imm_q >> `QERV_W;
      end
   end

   assign o_rf_rreq  = state_q == S_REQ;
   assign o_rf_rreg0 = rs1_q;
   assign o_rf_rreg1 = rs2_q;

   assign nib.en     = state_q == S_RUN;
   assign nib.first  = nib.en && (cnt_q == '0);
   assign nib.a      = zero_a_q ? '0 : i_rf_rdata0;
   assign nib.b      = use_imm_q ? imm_q[`QERV_W-1:0] : i_rf_rdata1;
   assign nib.alu_op = op_q;
   assign nib.rd     = rd_q;

endmodule

//--- logic/qerv_serial_alu.sv
`include "qerv_consts.svh"

module qerv_serial_alu (
   input  logic               clk,
   input  logic               i_rst_n,
   qerv_nibble_if.consumer    nib,
   output logic               o_rf_wen,
   output qerv_pkg::reg_idx_t o_rf_wreg,
   output qerv_pkg::nibble_t  o_rf_wdata
);
   import qerv_pkg::*;

   logic            carry_q;
   logic            sub;
   logic            cin;
   nibble_t         b_eff;
   logic [`QERV_W:0] sum;
   nibble_t         res;

   assign sub   = nib.alu_op == ALU_SUB;
   // Two's complement subtract, the +1 enters on nibble 0
   assign b_eff = sub ? ~nib.b : nib.b;
   assign cin   = nib.first ? sub : carry_q;
   assign sum   = {1'b0, nib.a} + {1'b0, b_eff} + {{`QERV_W{1'b0}}, cin};

   always_comb begin
      case (nib.alu_op)
         ALU_ADD,
         ALU_SUB:    res = sum[`QERV_W-1:0];
         ALU_AND:    res = nib.a & nib.b;
         ALU_OR:     res = nib.a | nib.b;
         ALU_XOR:    res = nib.a ^ nib.b;
         ALU_PASS_B: res = nib.b;
         default:    res = sum[`QERV_W-1:0];
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q  <= 1'b0;
         o_rf_wen <= 1'b0;
      end else begin
         if (nib.en)
            carry_q <= sum[`QERV_W];
         // x0 stays zero
         o_rf_wen <= nib.en && (nib.rd != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (nib.en) begin
         o_rf_wdata <= res;
         o_rf_wreg  <= nib.rd;
      end
   end

endmodule

//--- logic/qerv_top.sv
`include "qerv_consts.svh"

module qerv_top (
   input  logic                  clk,
   input  logic                  i_rst_n,
   // Instruction bus, read only
   output logic                  o_ibus_cyc,
   output logic [`QERV_XLEN-1:0] o_ibus_adr,
   input  logic [`QERV_XLEN-1:0] i_ibus_dat,
   input  logic                  i_ibus_ack,
   // Register file read port
   output logic                  o_rf_rreq,
   output qerv_pkg::reg_idx_t    o_rf_rreg0,
   output qerv_pkg::reg_idx_t    o_rf_rreg1,
   input  logic                  i_rf_ready,
   input  qerv_pkg::nibble_t     i_rf_rdata0,
   input  qerv_pkg::nibble_t     i_rf_rdata1,
   // Register file write port
   output logic                  o_rf_wen,
   output qerv_pkg::reg_idx_t    o_rf_wreg,
   output qerv_pkg::nibble_t     o_rf_wdata
);

   qerv_issue_if  issue_if ();
   qerv_nibble_if nib_if ();

   qerv_fetch fetch (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_dat (i_ibus_dat),
      .i_ibus_ack (i_ibus_ack),
      .issue      (issue_if.producer)
   );

   qerv_operand_seq operand_seq (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .issue       (issue_if.buffer),
      .o_rf_rreq   (o_rf_rreq),
      .o_rf_rreg0  (o_rf_rreg0),
      .o_rf_rreg1  (o_rf_rreg1),
      .i_rf_ready  (i_rf_ready),
      .i_rf_rdata0 (i_rf_rdata0),
      .i_rf_rdata1 (i_rf_rdata1),
      .nib         (nib_if.buffer)
   );

   qerv_serial_alu serial_alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .nib        (nib_if.consumer),
      .o_rf_wen   (o_rf_wen),
      .o_rf_wreg  (o_rf_wreg),
      .o_rf_wdata (o_rf_wdata)
   );

endmodule

//--- dv/qerv_rf_model.sv
module qerv_rf_model (
   input  logic        clk,
   input  logic        i_rreq,
   input  logic [4:0]  i_rreg0,
   input  logic [4:0]  i_rreg1,
   output logic        o_ready,
   output logic [3:0]  o_rdata0,
   output logic [3:0]  o_rdata1,
   input  logic        i_wen,
   input  logic [4:0]  i_wreg,
   input  logic [3:0]  i_wdata,
   output logic        o_wr_done,
   output logic [4:0]  o_wr_reg,
   output logic [31:0] o_wr_val,
   output int          o_wr_len
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] regs [0:31];
   logic [31:0] sh0;
   logic [31:0] sh1;
   logic [31:0] wr_acc;
   logic [31:0] rnd;
   logic [4:0]  rd0_q;
   logic [4:0]  rd1_q;
   int          seed = 32'h086ccef9;
   int          delay;
   int          out_cnt;
   int          wr_cnt;

   initial begin
      regs[0] = '0;
      for (int r = 1; r < 32; r++)
         regs[r] = $random(seed);
      o_ready   = 1'b0;
      o_rdata0  = '0;
      o_rdata1  = '0;
      o_wr_done = 1'b0;
      o_wr_reg  = '0;
      o_wr_val  = '0;
      o_wr_len  = 0;
      delay     = -1;
      out_cnt   = 0;
      wr_cnt    = 0;
   end

   always @(posedge clk) begin
      o_wr_done <= 1'b0;
      // Writes land nibble by nibble so a read at this edge sees them
      if (i_wen) begin
         if (wr_cnt < 8) begin
            wr_acc[4*wr_cnt +: 4] = i_wdata;
            if (i_wreg != 5'd0)
               regs[i_wreg][4*wr_cnt +: 4] = i_wdata;
         end
         o_wr_reg <= i_wreg;
         wr_cnt++;
      end else if (wr_cnt > 0) begin
         o_wr_done <= 1'b1;
         o_wr_val  <= wr_acc;
         o_wr_len  <= wr_cnt;
         wr_cnt = 0;
      end
      if (o_ready) begin
         o_ready <= 1'b0;
         out_cnt = 8;
      end
      if (out_cnt > 0) begin
         o_rdata0 <= sh0[3:0];
         o_rdata1 <= sh1[3:0];
         sh0 = sh0 >> 4;
         sh1 = sh1 >> 4;
         out_cnt--;
      end
      if (i_rreq) begin
         rd0_q = i_rreg0;
         rd1_q = i_rreg1;
         rnd   = $random(seed);
         delay = int'(rnd[1:0]);
      end
      if (delay == 0) begin
         sh0 = regs[rd0_q];
         sh1 = regs[rd1_q];
         o_ready <= 1'b1;
      end
      if (delay >= 0)
         delay--;
   end

endmodule

//--- dv/qerv_tb.sv
`include "qerv_consts.svh"

module qerv_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int prog_len   = 60;
   localparam int wait_limit = 2000;

   logic        clk;
   logic        i_rst_n;
   logic        o_ibus_cyc;
   logic [31:0] o_ibus_adr;
   logic [31:0] i_ibus_dat;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   logic [4:0]  o_rf_rreg0;
   logic [4:0]  o_rf_rreg1;
   logic        i_rf_ready;
   logic [3:0]  i_rf_rdata0;
   logic [3:0]  i_rf_rdata1;
   logic        o_rf_wen;
   logic [4:0]  o_rf_wreg;
   logic [3:0]  o_rf_wdata;
   logic        wr_done;
   logic [4:0]  wr_reg;
   logic [31:0] wr_val;
   int          wr_len;

   logic [31:0] prog [0:prog_len-1];
   logic [31:0] ref_regs [0:31];
   int          seed = 32'h086ccef9;
   int          fetch_idx;
   int          writes_seen;
   bit          bus_busy;
   int          bus_wait;
   logic [31:0] bus_adr;
   logic [31:0] bus_rnd;
   int          pass_cnt [1:6];
   int          fail_cnt [1:6];
   bit          timed_out;

   qerv_top uut (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_ibus_adr  (o_ibus_adr),
      .i_ibus_dat  (i_ibus_dat),
      .i_ibus_ack  (i_ibus_ack),
      .o_rf_rreq   (o_rf_rreq),
      .o_rf_rreg0  (o_rf_rreg0),
      .o_rf_rreg1  (o_rf_rreg1),
      .i_rf_ready  (i_rf_ready),
      .i_rf_rdata0 (i_rf_rdata0),
      .i_rf_rdata1 (i_rf_rdata1),
      .o_rf_wen    (o_rf_wen),
      .o_rf_wreg   (o_rf_wreg),
      .o_rf_wdata  (o_rf_wdata)
   );

   qerv_rf_model rf (
      .clk       (clk),
      .i_rreq    (o_rf_rreq),
      .i_rreg0   (o_rf_rreg0),
      .i_rreg1   (o_rf_rreg1),
      .o_ready   (i_rf_ready),
      .o_rdata0  (i_rf_rdata0),
      .o_rdata1  (i_rf_rdata1),
      .i_wen     (o_rf_wen),
      .i_wreg    (o_rf_wreg),
      .i_wdata   (o_rf_wdata),
      .o_wr_done (wr_done),
      .o_wr_reg  (wr_reg),
      .o_wr_val  (wr_val),
      .o_wr_len  (wr_len)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want, input int beh);
      if (got !== want) begin
         $display("error t=%0t %s got 0x%h expected 0x%h", $time, name, got, want);
         fail_cnt[beh]++;
      end else begin
         pass_cnt[beh]++;
      end
   endtask

   function automatic bit writes_reg(input logic [31:0] insn);
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = insn[14:12];
      f7 = insn[31:25];
      if (insn[11:7] == 5'd0)
         return 1'b0;
      case (insn[6:0])
         `QERV_OPC_OP:
            return (f7 == 7'd0 && f3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
                   (f7 == `QERV_F7_SUB && f3 == `QERV_F3_ADD);
         `QERV_OPC_OP_IMM: return f3 inside {3'b000, 3'b100, 3'b110, 3'b111};
         `QERV_OPC_LUI:    return 1'b1;
         default:          return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] ref_result(input logic [31:0] insn,
                                              input logic [31:0] a, input logic [31:0] b);
      logic [31:0] imm;
      imm = {{20{insn[31]}}, insn[31:20]};
      if (insn[6:0] == `QERV_OPC_LUI)
         return {insn[31:12], 12'd0};
      // Immediate forms replace rs2 with the sign-extended imm12
      if (insn[6:0] == `QERV_OPC_OP_IMM)
         b = imm;
      case (insn[14:12])
         `QERV_F3_ADD: begin
            if (insn[6:0] == `QERV_OPC_OP && insn[31:25] == `QERV_F7_SUB)
               return a - b;
            return a + b;
         end
         `QERV_F3_XOR: return a ^ b;
         `QERV_F3_OR:  return a | b;
         default:      return a & b;
      endcase
   endfunction

   function automatic logic [31:0] program_word(input logic [31:0] adr);
      int idx;
      idx = int'((adr - `QERV_RESET_PC) >> 2);
      if (idx < prog_len)
         return prog[idx];
      // Opcode 0 is outside the subset
      return {adr[26:2], 7'd0};
   endfunction

   task automatic build_program;
      logic [31:0] r;
      logic [31:0] w;
      int          kind;
      for (int i = 0; i < prog_len; i++) begin
         r    = $random(seed);
         w    = $random(seed);
         kind = int'(r % 32'd12);
         case (kind)
            0:  prog[i] = {7'd0, w[24:15], `QERV_F3_ADD, w[11:7], `QERV_OPC_OP};
            1:  prog[i] = {`QERV_F7_SUB, w[24:15], `QERV_F3_ADD, w[11:7], `QERV_OPC_OP};
            2:  prog[i] = {7'd0, w[24:15], `QERV_F3_AND, w[11:7], `QERV_OPC_OP};
            3:  prog[i] = {7'd0, w[24:15], `QERV_F3_OR, w[11:7], `QERV_OPC_OP};
            4:  prog[i] = {7'd0, w[24:15], `QERV_F3_XOR, w[11:7], `QERV_OPC_OP};
            5:  prog[i] = {w[31:15], `QERV_F3_ADD, w[11:7], `QERV_OPC_OP_IMM};
            6:  prog[i] = {w[31:15], `QERV_F3_AND, w[11:7], `QERV_OPC_OP_IMM};
            7:  prog[i] = {w[31:15], `QERV_F3_OR, w[11:7], `QERV_OPC_OP_IMM};
            8:  prog[i] = {w[31:15], `QERV_F3_XOR, w[11:7], `QERV_OPC_OP_IMM};
            9:  prog[i] = {w[31:7], `QERV_OPC_LUI};
            10: prog[i] = {`QERV_F7_SUB, w[24:15], `QERV_F3_ADD, 5'd0, `QERV_OPC_OP};
            default: begin
               // Load, branch, MUL and SLLI words
               case (r[5:4])
                  2'd0:    prog[i] = {w[31:7], 7'b0000011};
                  2'd1:    prog[i] = {w[31:7], 7'b1100011};
                  2'd2:    prog[i] = {7'b0000001, w[24:7], `QERV_OPC_OP};
                  default: prog[i] = {w[31:15], 3'b001, w[11:7], `QERV_OPC_OP_IMM};
               endcase
            end
         endcase
      end
   endtask

   function automatic string behavior_name(input int b);
      case (b)
         1:       return "fetch address sequence";
         2:       return "register ALU ops";
         3:       return "immediate ALU ops";
         4:       return "LUI";
         5:       return "x0 and unsupported words";
         default: return "write order and run length";
      endcase
   endfunction

   // Wishbone responder with 0 to 3 wait cycles
   always @(posedge clk) begin
      if (!i_rst_n || i_ibus_ack) begin
         i_ibus_ack <= 1'b0;
         bus_busy = 1'b0;
      end else if (o_ibus_cyc) begin
         if (!bus_busy) begin
            bus_busy = 1'b1;
            bus_adr  = o_ibus_adr;
            check_value("o_ibus_adr", o_ibus_adr,
                        `QERV_RESET_PC + 32'(fetch_idx) * 32'd4, 1);
            bus_rnd  = $random(seed);
            bus_wait = int'(bus_rnd[1:0]);
         end else begin
            check_value("o_ibus_adr held", o_ibus_adr, bus_adr, 1);
         end
         if (bus_wait == 0) begin
            i_ibus_ack <= 1'b1;
            i_ibus_dat <= program_word(o_ibus_adr);
            fetch_idx  <= fetch_idx + 1;
         end else begin
            bus_wait--;
         end
      end
   end

   always @(posedge clk) begin
      if (i_rst_n && o_rf_wen)
         check_value("o_rf_wreg nonzero", {31'd0, o_rf_wreg != 5'd0}, 32'd1, 5);
      if (wr_done)
         writes_seen <= writes_seen + 1;
   end

   initial begin
      logic [31:0] insn;
      logic [31:0] want;
      int          beh;
      int          cycles;
      int          expected_writes;
      int          tot_pass;
      int          tot_fail;

      i_rst_n         = 1'b0;
      i_ibus_ack      = 1'b0;
      i_ibus_dat      = '0;
      fetch_idx       = 0;
      writes_seen     = 0;
      bus_busy        = 1'b0;
      bus_wait        = 0;
      timed_out       = 1'b0;
      expected_writes = 0;
      tot_pass        = 0;
      tot_fail        = 0;
      for (int b = 1; b <= 6; b++) begin
         pass_cnt[b] = 0;
         fail_cnt[b] = 0;
      end
      build_program();
      repeat (5) @(posedge clk);
      i_rst_n <= 1'b1;
      for (int r = 0; r < 32; r++)
         ref_regs[r] = rf.regs[r];

      for (int i = 0; i < prog_len && !timed_out; i++) begin
         insn = prog[i];
         if (writes_reg(insn)) begin
            expected_writes++;
            want = ref_result(insn, ref_regs[insn[19:15]], ref_regs[insn[24:20]]);
            beh  = (insn[6:0] == `QERV_OPC_OP) ? 2 :
                   (insn[6:0] == `QERV_OPC_OP_IMM) ? 3 : 4;
            cycles = 0;
            @(posedge clk);
            while (!wr_done && cycles < wait_limit) begin
               @(posedge clk);
               cycles++;
            end
            if (!wr_done) begin
               $display("timeout: no register write arrived for instruction %0d", i);
               timed_out = 1'b1;
            end else begin
               check_value("o_rf_wreg", 32'(wr_reg), 32'(insn[11:7]), 6);
               check_value("o_rf_wen run length", wr_len, 32'd8, 6);
               check_value("o_rf_wdata", wr_val, want, beh);
               ref_regs[insn[11:7]] = want;
            end
         end
      end

      // Fetch far enough past the end that the last word has retired
      cycles = 0;
      while (!timed_out && fetch_idx < prog_len + 4 && cycles < wait_limit) begin
         @(posedge clk);
         cycles++;
      end
      if (cycles >= wait_limit) begin
         $display("timeout: fetch stalled before the end of the program");
         timed_out = 1'b1;
      end
      check_value("register write count", writes_seen, expected_writes, 5);

      for (int b = 1; b <= 6; b++) begin
         $display("behavior %0d %s: %0d checks, %0d failed", b, behavior_name(b),
                  pass_cnt[b] + fail_cnt[b], fail_cnt[b]);
         tot_pass += pass_cnt[b];
         tot_fail += fail_cnt[b];
      end
      $display("checks passed %0d failed %0d", tot_pass, tot_fail);
      if (tot_fail == 0 && !timed_out)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+logic
logic/qerv_pkg.sv
logic/qerv_if.sv
logic/qerv_fetch.sv
logic/qerv_operand_seq.sv
logic/qerv_serial_alu.sv
logic/qerv_top.sv
dv/qerv_rf_model.sv
dv/qerv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# Modules without their own timeunit take the testbench's
verilator --binary --timing --timescale 1ns/100ps \
   -f verilog.f --top-module qerv_tb --Mdir obj_dir -o qerv_sim

./obj_dir/qerv_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
   exit 0
fi
exit 1
